// File: rtl/harness_pkg.sv
package harness_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;  // One enable per byte lane

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

    // Core side request, held stable until gnt
    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        data_t wdata;
    } obi_req_t;

    typedef struct packed {
        logic  gnt;     // Single cycle grant
        logic  rvalid;  // Single cycle response
        data_t rdata;
    } obi_rsp_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        be_t   sel;
        addr_t addr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        BR_IDLE,  // Waiting for a request
        BR_BUS,   // Wishbone cycle open
        BR_RESP   // Returning the response
    } bridge_state_e;

endpackage

// File: rtl/core_reset_ctrl.sv
`timescale 1ns/1ps

module core_reset_ctrl #(
    parameter int RESET_CLK_CYCLES = 16
) (
    input  logic sys_clk,
    input  logic rst_i,
    output logic core_rst_o
);

    localparam int CNT_W = (RESET_CLK_CYCLES > 0) ? $clog2(RESET_CLK_CYCLES + 1) : 1;

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t hold_cnt;

    // Counter is reloaded for as long as the system reset is asserted
    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            hold_cnt   <= cnt_t'(RESET_CLK_CYCLES);
            core_rst_o <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt   <= hold_cnt - 1'b1;  // Core still held
        end else begin
            core_rst_o <= 1'b0;  // Release once the count is spent
        end
    end

endmodule

// File: rtl/obi_wb_bridge.sv
`timescale 1ns/1ps

module obi_wb_bridge
    import harness_pkg::*;
(
    input  logic     sys_clk,
    input  logic     rst_i,
    input  logic     core_rst_i,
    input  obi_req_t obi_req_i,
    output obi_rsp_t obi_rsp_o,
    output wb_req_t  wb_req_o,
    input  wb_rsp_t  wb_rsp_i
);

    bridge_state_e state_q;
    bridge_state_e state_d;

    logic  grant;
    logic  bus_open;
    logic  bus_done;

    // Latched request payload
    logic  we_q;
    be_t   sel_q;
    addr_t addr_q;
    data_t wdata_q;

    data_t rdata_q;  // Word returned with the ack

    // Grant only from idle and never while the core is held in reset
    assign grant    = (state_q == BR_IDLE) && obi_req_i.req && !core_rst_i;
    assign bus_open = (state_q == BR_BUS);
    assign bus_done = bus_open && wb_rsp_i.ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BR_IDLE: begin
                if (grant) begin
                    state_d = BR_BUS;
                end
            end
            BR_BUS: begin
                if (wb_rsp_i.ack) begin
                    state_d = BR_RESP;
                end
            end
            BR_RESP: state_d = BR_IDLE;  // rvalid lasts one cycle
            default: state_d = BR_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state_q <= BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload capture and read data register
    always_ff @(posedge sys_clk) begin
        if (grant) begin
            we_q    <= obi_req_i.we;
            sel_q   <= obi_req_i.be;
            addr_q  <= obi_req_i.addr;
            wdata_q <= obi_req_i.wdata;
        end
        if (bus_done) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    // Wishbone master side, cyc and stb move together
    always_comb begin
        wb_req_o.cyc  = bus_open;
        wb_req_o.stb  = bus_open;
        wb_req_o.we   = we_q;
        wb_req_o.sel  = sel_q;
        wb_req_o.addr = addr_q;
        wb_req_o.dat  = wdata_q;
    end

    // Core side response
    always_comb begin
        obi_rsp_o.gnt    = grant;
        obi_rsp_o.rvalid = (state_q == BR_RESP);
        obi_rsp_o.rdata  = rdata_q;
    end

endmodule

// File: rtl/harness_memory.sv
`timescale 1ns/1ps

module harness_memory
    import harness_pkg::*;
#(
    parameter int MEM_WORDS   = 1024,
    parameter int WAIT_STATES = 1
) (
    input  logic    sys_clk,
    input  wb_req_t a_req_i,
    output wb_rsp_t a_rsp_o,
    input  wb_req_t b_req_i,
    output wb_rsp_t b_rsp_o,
    input  logic    rst_i
);

    localparam int NPORT = 2;
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    data_t mem [MEM_WORDS];

    wb_req_t          port_req [NPORT];  // Index 0 fetch, 1 data
    idx_t             port_idx [NPORT];
    cnt_t             wait_cnt [NPORT];
    data_t            rdata_q  [NPORT];
    logic [NPORT-1:0] ack_q;
    logic [NPORT-1:0] fire;  // Access happens on this edge

    // Word address, wrapping over the depth
    function automatic idx_t word_index(addr_t addr);
        return idx_t'((addr >> 2) % MEM_WORDS);
    endfunction

    assign port_req[0] = a_req_i;
    assign port_req[1] = b_req_i;

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            port_idx[p] = word_index(port_req[p].addr);
            fire[p]     = port_req[p].stb && !ack_q[p] &&
                          (wait_cnt[p] == cnt_t'(WAIT_STATES));
        end
    end

    // Wait-state counters and ack pulses
    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            ack_q <= '0;
            for (int p = 0; p < NPORT; p++) begin
                wait_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NPORT; p++) begin
                ack_q[p] <= fire[p];
                if (fire[p] || !port_req[p].stb) begin
                    wait_cnt[p] <= '0;
                end else if (!ack_q[p]) begin
                    wait_cnt[p] <= wait_cnt[p] + 1'b1;
                end
            end
        end
    end

    // Reads see the old word. Port 1 is written last so the data port wins
    always_ff @(posedge sys_clk) begin
        for (int p = 0; p < NPORT; p++) begin
            if (fire[p]) begin
                rdata_q[p] <= mem[port_idx[p]];
                if (port_req[p].we) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (port_req[p].sel[b]) begin
                            mem[port_idx[p]][8*b +: 8] <= port_req[p].dat[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    assign a_rsp_o = '{ack: ack_q[0], dat: rdata_q[0]};
    assign b_rsp_o = '{ack: ack_q[1], dat: rdata_q[1]};

endmodule

// File: rtl/processorci_harness.sv
`timescale 1ns/1ps

module processorci_harness
    import harness_pkg::*;
#(
    parameter int MEM_WORDS        = 1024,
    parameter int WAIT_STATES      = 1,
    parameter int RESET_CLK_CYCLES = 16
) (
    input  logic     sys_clk,
    input  logic     rst_i,
    input  obi_req_t instr_req_i,
    output obi_rsp_t instr_rsp_o,
    input  obi_req_t data_req_i,
    output obi_rsp_t data_rsp_o,
    output logic     core_rst_o
);

    wb_req_t instr_wb_req;
    wb_rsp_t instr_wb_rsp;
    wb_req_t data_wb_req;
    wb_rsp_t data_wb_rsp;

    // Holds the core off the buses after system reset
    core_reset_ctrl #(
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
    ) u_core_reset_ctrl (
        .sys_clk    (sys_clk),
        .rst_i      (rst_i),
        .core_rst_o (core_rst_o)
    );

    obi_wb_bridge u_instr_bridge (
        .sys_clk    (sys_clk),
        .rst_i      (rst_i),
        .core_rst_i (core_rst_o),
        .obi_req_i  (instr_req_i),
        .obi_rsp_o  (instr_rsp_o),
        .wb_req_o   (instr_wb_req),
        .wb_rsp_i   (instr_wb_rsp)
    );

    obi_wb_bridge u_data_bridge (
        .sys_clk    (sys_clk),
        .rst_i      (rst_i),
        .core_rst_i (core_rst_o),
        .obi_req_i  (data_req_i),
        .obi_rsp_o  (data_rsp_o),
        .wb_req_o   (data_wb_req),
        .wb_rsp_i   (data_wb_rsp)
    );

    // Fetch on port A, data on port B
    harness_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_harness_memory (
        .sys_clk (sys_clk),
        .a_req_i (instr_wb_req),
        .a_rsp_o (instr_wb_rsp),
        .b_req_i (data_wb_req),
        .b_rsp_o (data_wb_rsp),
        .rst_i   (rst_i)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // Free running

endmodule

// File: tb/harness_assertions.sv
`timescale 1ns/1ps

module harness_assertions
    import harness_pkg::*;
#(
    parameter int WAIT_STATES = 1
) (
    input logic     sys_clk_i,
    input logic     rst_i,
    input logic     core_rst_i,
    input obi_req_t instr_req_i,
    input obi_rsp_t instr_rsp_i,
    input obi_req_t data_req_i,
    input obi_rsp_t data_rsp_i,
    input wb_req_t  instr_wb_req_i,
    input wb_rsp_t  instr_wb_rsp_i,
    input wb_req_t  data_wb_req_i,
    input wb_rsp_t  data_wb_rsp_i
);

    int fail_count = 0;  // Assertion failures seen so far

    task automatic note_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Grant needs a request and a released core
    property p_gnt_legal(obi_req_t req, obi_rsp_t rsp);
        @(posedge sys_clk_i) disable iff (rst_i)
            rsp.gnt |-> (req.req && !core_rst_i);
    endproperty

    property p_rvalid_after_gnt(obi_rsp_t rsp);
        @(posedge sys_clk_i) disable iff (rst_i)
            rsp.gnt |=> (!rsp.rvalid) [*(WAIT_STATES + 2)] ##1 rsp.rvalid;
    endproperty

    // No stray rvalid without a grant before it
    property p_rvalid_has_gnt(obi_rsp_t rsp);
        @(posedge sys_clk_i) disable iff (rst_i)
            rsp.rvalid |-> $past(rsp.gnt, WAIT_STATES + 3);
    endproperty

    property p_wb_legal(wb_req_t req, wb_rsp_t rsp);
        @(posedge sys_clk_i) disable iff (rst_i)
            (req.cyc == req.stb) && (!rsp.ack || req.stb);
    endproperty

    a_instr_gnt: assert property (p_gnt_legal(instr_req_i, instr_rsp_i))
        else note_failure("instr gnt without req or during core reset");
    a_data_gnt: assert property (p_gnt_legal(data_req_i, data_rsp_i))
        else note_failure("data gnt without req or during core reset");
    a_instr_rvalid: assert property (p_rvalid_after_gnt(instr_rsp_i))
        else note_failure("instr rvalid not exactly once at the expected cycle");
    a_data_rvalid: assert property (p_rvalid_after_gnt(data_rsp_i))
        else note_failure("data rvalid not exactly once at the expected cycle");
    a_instr_orphan: assert property (p_rvalid_has_gnt(instr_rsp_i))
        else note_failure("instr rvalid without a matching gnt");
    a_data_orphan: assert property (p_rvalid_has_gnt(data_rsp_i))
        else note_failure("data rvalid without a matching gnt");
    a_instr_wb: assert property (p_wb_legal(instr_wb_req_i, instr_wb_rsp_i))
        else note_failure("instr Wishbone cyc/stb/ack rule broken");
    a_data_wb: assert property (p_wb_legal(data_wb_req_i, data_wb_rsp_i))
        else note_failure("data Wishbone cyc/stb/ack rule broken");

endmodule

bind processorci_harness harness_assertions #(
    .WAIT_STATES (WAIT_STATES)
) u_harness_assertions (
    .sys_clk_i      (sys_clk),
    .rst_i          (rst_i),
    .core_rst_i     (core_rst_o),
    .instr_req_i    (instr_req_i),
    .instr_rsp_i    (instr_rsp_o),
    .data_req_i     (data_req_i),
    .data_rsp_i     (data_rsp_o),
    .instr_wb_req_i (instr_wb_req),
    .instr_wb_rsp_i (instr_wb_rsp),
    .data_wb_req_i  (data_wb_req),
    .data_wb_rsp_i  (data_wb_rsp)
);

// File: tb/tb_processorci_harness.sv
`timescale 1ns/1ps

module tb_processorci_harness
    import harness_pkg::*;
();

    localparam int MEM_WORDS        = 1024;
    localparam int WAIT_STATES      = 1;
    localparam int RESET_CLK_CYCLES = 16;
    localparam int RESET_CYCLES     = 8;
    localparam int LATENCY          = 3 + WAIT_STATES;  // gnt to rvalid
    localparam int TIMEOUT          = 64;
    localparam int RAND_OPS         = 200;
    localparam int IPORT            = 0;
    localparam int DPORT            = 1;

    logic     sys_clk;
    logic     rst;
    logic     core_rst;
    obi_req_t instr_req;
    obi_rsp_t instr_rsp;
    obi_req_t data_req;
    obi_rsp_t data_rsp;

    data_t ref_mem [MEM_WORDS];  // Expected memory contents
    data_t rng_state = 32'd18280;
    logic  data_done;

    tb_clock_gen #(
        .PERIOD_NS (8)
    ) u_tb_clock_gen (
        .clk_o (sys_clk)
    );

    processorci_harness #(
        .MEM_WORDS        (MEM_WORDS),
        .WAIT_STATES      (WAIT_STATES),
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
    ) u_processorci_harness (
        .sys_clk     (sys_clk),
        .rst_i       (rst),
        .instr_req_i (instr_req),
        .instr_rsp_o (instr_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .core_rst_o  (core_rst)
    );

    function automatic data_t xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Addresses wrap over the memory depth
    function automatic int word_idx(addr_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic obi_rsp_t rsp_of(int port);
        return (port == IPORT) ? instr_rsp : data_rsp;
    endfunction

    task automatic stop_failed();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_failed();
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic ref_write(input addr_t addr, input be_t be, input data_t wdata);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                ref_mem[word_idx(addr)][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic drive_req(input int port, input obi_req_t r);
        if (port == IPORT) begin
            instr_req <= r;
        end else begin
            data_req <= r;
        end
    endtask

    task automatic drop_req(input int port);
        if (port == IPORT) begin
            instr_req.req <= 1'b0;
        end else begin
            data_req.req <= 1'b0;
        end
    endtask

    // Returns at the falling edge of the grant cycle
    task automatic wait_gnt(input int port);
        int n;
        obi_rsp_t rsp;
        n = 0;
        @(negedge sys_clk);
        rsp = rsp_of(port);
        while (!rsp.gnt) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("Timed out waiting for gnt");
            end
            @(negedge sys_clk);
            rsp = rsp_of(port);
        end
    endtask

    // Counts cycles to rvalid; no new gnt may show up meanwhile
    task automatic wait_rvalid(input int port, output int lat);
        obi_rsp_t rsp;
        lat = 0;
        do begin
            @(negedge sys_clk);
            lat++;
            rsp = rsp_of(port);
            if (lat > TIMEOUT) begin
                abort_run("Timed out waiting for rvalid");
            end
            check_bit("gnt before rvalid", 1'b0, rsp.gnt);
        end while (!rsp.rvalid);
    endtask

    task automatic access(input int port, input logic we, input be_t be, input addr_t addr,
                          input data_t wdata, output data_t rdata);
        int lat;
        obi_rsp_t rsp;
        @(posedge sys_clk);
        drive_req(port, '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata});
        wait_gnt(port);
        @(posedge sys_clk);
        drop_req(port);
        wait_rvalid(port, lat);
        check_latency("gnt to rvalid cycles", LATENCY, lat);
        rsp = rsp_of(port);
        rdata = rsp.rdata;
    endtask

    task automatic obi_write(input int port, input be_t be, input addr_t addr, input data_t wdata);
        data_t unused;
        access(port, 1'b1, be, addr, wdata, unused);  // rdata holds the old word
        ref_write(addr, be, wdata);
    endtask

    task automatic obi_read(input int port, input addr_t addr);
        data_t rd;
        access(port, 1'b0, 4'hF, addr, '0, rd);
        check_data((port == IPORT) ? "instr rdata" : "data rdata", ref_mem[word_idx(addr)], rd);
    endtask

    task automatic test_reset();
        int high_edges;
        int lat;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge sys_clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge sys_clk);
            check_bit("core_rst_o in reset", 1'b1, core_rst);
            check_bit("data gnt in reset", 1'b0, data_rsp.gnt);
        end
        high_edges = 0;
        do begin
            @(posedge sys_clk);
            @(negedge sys_clk);
            if (core_rst) begin
                high_edges++;
                check_bit("data gnt in core reset", 1'b0, data_rsp.gnt);
            end
            if (high_edges > TIMEOUT) begin
                abort_run("Timed out waiting for core_rst_o to fall");
            end
        end while (core_rst);
        check_latency("core_rst_o hold edges", RESET_CLK_CYCLES, high_edges);
        check_bit("data gnt after core reset", 1'b1, data_rsp.gnt);
        @(posedge sys_clk);
        drop_req(DPORT);
        wait_rvalid(DPORT, lat);  // Word 0 is still unwritten, data ignored
        check_latency("gnt to rvalid cycles", LATENCY, lat);
    endtask

    task automatic test_word_rw();
        addr_t addrs [4];
        addrs = '{32'h100, 32'h104, 32'hFFC, addr_t'(MEM_WORDS * 4 + 32'h20)};
        foreach (addrs[i]) begin
            obi_write(DPORT, 4'hF, addrs[i], xorshift());
            obi_read(DPORT, addrs[i]);
            obi_read(IPORT, addrs[i]);
        end
        obi_read(IPORT, 32'h20);  // Same word as the wrapped write
    endtask

    task automatic test_byte_enables();
        be_t bes [7];
        bes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0110};
        obi_write(DPORT, 4'hF, 32'h40, 32'h1122_3344);
        foreach (bes[i]) begin
            obi_write(DPORT, bes[i], 32'h40, xorshift());
            obi_read(DPORT, 32'h40);
        end
        obi_read(IPORT, 32'h40);
    endtask

    task automatic test_latency_backpressure();
        int lat;
        data_t wval;
        obi_rsp_t rsp;
        wval = xorshift();
        @(posedge sys_clk);
        drive_req(DPORT, '{req: 1'b1, we: 1'b1, be: 4'hF, addr: 32'h80, wdata: wval});
        wait_gnt(DPORT);
        ref_write(32'h80, 4'hF, wval);
        @(posedge sys_clk);
        // Next request right behind the grant
        drive_req(DPORT, '{req: 1'b1, we: 1'b0, be: 4'hF, addr: 32'h80, wdata: '0});
        wait_rvalid(DPORT, lat);
        check_latency("gnt to rvalid cycles", LATENCY, lat);
        wait_gnt(DPORT);
        @(posedge sys_clk);
        drop_req(DPORT);
        wait_rvalid(DPORT, lat);
        check_latency("gnt to rvalid cycles", LATENCY, lat);
        rsp = rsp_of(DPORT);
        check_data("data rdata", ref_mem[word_idx(32'h80)], rsp.rdata);
        fork
            obi_read(IPORT, 32'h80);
            obi_read(DPORT, 32'h100);
        join
        fork
            obi_read(IPORT, 32'h40);
            obi_write(DPORT, 4'hF, 32'h44, xorshift());
        join
        obi_read(IPORT, 32'h44);
    endtask

    task automatic test_random_traffic();
        data_t r;
        addr_t a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            obi_write(DPORT, 4'hF, addr_t'(i * 4), xorshift());
        end
        data_done = 1'b0;
        fork
            begin
                for (int i = 0; i < RAND_OPS; i++) begin
                    r = xorshift();
                    a = addr_t'((MEM_WORDS / 2 + r % (MEM_WORDS / 2)) * 4);  // Upper half
                    if (r[31]) begin
                        obi_write(DPORT, be_t'(r[27:24]), a, xorshift());
                    end else begin
                        obi_read(DPORT, a);
                    end
                end
                data_done = 1'b1;
            end
            begin
                while (!data_done) begin
                    obi_read(IPORT, addr_t'((xorshift() % (MEM_WORDS / 2)) * 4));
                end
            end
        join
    endtask

    initial begin
        rst       <= 1'b1;
        instr_req <= '0;
        data_req  <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: '0, wdata: '0};  // Held through reset
        data_done = 1'b0;
        test_reset();
        test_word_rw();
        test_byte_enables();
        test_latency_backpressure();
        test_random_traffic();
        repeat (4) @(posedge sys_clk);
        if (u_processorci_harness.u_harness_assertions.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Bus protocol assertions failed");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: filelist.f
rtl/harness_pkg.sv
rtl/core_reset_ctrl.sv
rtl/obi_wb_bridge.sv
rtl/harness_memory.sv
rtl/processorci_harness.sv
tb/tb_clock_gen.sv
tb/harness_assertions.sv
tb/tb_processorci_harness.sv
